/* rtl/galvo_defs.svh */
`ifndef GALVO_DEFS_SVH
`define GALVO_DEFS_SVH

// scan position and vector memory address, 2048 entries per axis
`define GALVO_POS_W 11

`define GALVO_SAMPLE_W 12    // dac sample bits
`define GALVO_CMD_W 4        // dac command nibble
`define GALVO_WORD_W 16      // one spi frame

// idle clocks after every spi word before the next one may start
`define GALVO_GAP_CYCLES 15

`define GALVO_SCLK_DIV 2     // control clocks per sclk half period
`define GALVO_SYNC_STAGES 2  // flops in the pixel pulse synchronizer

`endif

/* rtl/galvo_seq_pkg.sv */
`include "galvo_defs.svh"

package galvo_seq_pkg;

   typedef enum logic {
      AXIS_H = 1'b0,   // horizontal mirror
      AXIS_V = 1'b1    // vertical mirror
   } axis_e;

   typedef enum logic [2:0] {
      ST_IDLE   = 3'd0,  // wait for pixel
      ST_PREP   = 3'd1,  // memory read of new position
      ST_SEND_H = 3'd2,
      ST_GAP_H  = 3'd3,
      ST_SEND_V = 3'd4,
      ST_GAP_V  = 3'd5
   } seq_state_e;

   // load and update commands of the dac
   typedef enum logic [`GALVO_CMD_W-1:0] {
      CMD_LOAD_A = 4'b0001,  // channel a, horizontal
      CMD_LOAD_B = 4'b0100   // channel b, vertical
   } dac_cmd_e;

   typedef struct packed {
      dac_cmd_e                   cmd;     // upper nibble, sent first
      logic [`GALVO_SAMPLE_W-1:0] sample;
   } dac_word_t;

endpackage

/* rtl/galvo_cfg_pkg.sv */
`include "galvo_defs.svh"

package galvo_cfg_pkg;

   import galvo_seq_pkg::*;

   // scan setup from the host, static while scanning
   typedef struct packed {
      logic                    manual_mode;  // manual positions, v word every pixel
      logic [`GALVO_POS_W-1:0] h_max;        // last horizontal index
      logic [`GALVO_POS_W-1:0] v_max;        // last vertical index
   } scan_cfg_t;

   typedef struct packed {
      logic [`GALVO_SAMPLE_W-1:0] h_pos;  // raw dac code
      logic [`GALVO_SAMPLE_W-1:0] v_pos;
   } manual_pos_t;

   // one write per cycle into either vector memory
   typedef struct packed {
      logic                       en;
      axis_e                      axis;   // selects the memory
      logic [`GALVO_POS_W-1:0]    addr;
      logic [`GALVO_SAMPLE_W-1:0] data;
   } vec_wr_t;

endpackage

/* rtl/pulse_sync.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module pulse_sync (
   input  logic clk_adc,
   input  logic rst_adc_n,
   input  logic pixel_done,      // one clk_adc cycle
   input  logic s_axi_h_aclk,
   input  logic rst_control_n,
   output logic pixel_pulse      // one control cycle
);

   localparam int STAGES = `GALVO_SYNC_STAGES;

   logic              toggle_q;     // adc domain
   logic [STAGES-1:0] sync_q;       // control domain chain
   logic              sync_last_q;  // for edge detect

   always_ff @(posedge clk_adc or negedge rst_adc_n) begin
      if (!rst_adc_n) begin
         toggle_q <= 1'b0;
      end else if (pixel_done) begin
         toggle_q <= ~toggle_q;  // level change per pulse
      end
   end

   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         sync_q      <= '0;
         sync_last_q <= 1'b0;
      end else begin
         sync_q      <= {sync_q[STAGES-2:0], toggle_q};
         sync_last_q <= sync_q[STAGES-1];
      end
   end

   assign pixel_pulse = sync_q[STAGES-1] ^ sync_last_q;  // either edge of toggle

   // adc pulses must be spaced wider than the synchronizer
   a_single_pulse: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
      pixel_pulse |=> !pixel_pulse);

endmodule

/* rtl/scan_position.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module scan_position
   import galvo_cfg_pkg::*;
(
   input  logic                    s_axi_h_aclk,
   input  logic                    rst_control_n,
   input  logic                    pixel_pulse,
   input  scan_cfg_t               cfg,
   output logic [`GALVO_POS_W-1:0] h_pos,
   output logic [`GALVO_POS_W-1:0] v_pos,
   output logic                    row_wrap    // pulse that ends a row
);

   logic h_last;
   logic v_last;

   // >= so a limit lowered mid-scan still wraps
   assign h_last   = (h_pos >= cfg.h_max);
   assign v_last   = (v_pos >= cfg.v_max);
   assign row_wrap = pixel_pulse && h_last;

   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         h_pos <= '0;
      end else if (pixel_pulse) begin
         h_pos <= h_last ? '0 : h_pos + 1'b1;
      end
   end

   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         v_pos <= '0;
      end else if (row_wrap) begin  // one line per h wrap
         if (v_last) begin
            v_pos <= '0;  // frame done
         end else begin
            v_pos <= v_pos + 1'b1;
         end
      end
   end

endmodule

/* rtl/vector_ram.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module vector_ram (
   input  logic                       s_axi_h_aclk,
   input  logic                       wr_en,
   input  logic [`GALVO_POS_W-1:0]    wr_addr,
   input  logic [`GALVO_SAMPLE_W-1:0] wr_data,
   input  logic [`GALVO_POS_W-1:0]    rd_addr,
   output logic [`GALVO_SAMPLE_W-1:0] rd_data   // one cycle after rd_addr
);

   localparam int DEPTH = 1 << `GALVO_POS_W;

   logic [`GALVO_SAMPLE_W-1:0] mem [DEPTH];  // block ram

   always_ff @(posedge s_axi_h_aclk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;  // host load
      end
   end

   always_ff @(posedge s_axi_h_aclk) begin
      rd_data <= mem[rd_addr];  // registered read port
   end

endmodule

/* rtl/galvo_sequencer.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module galvo_sequencer
   import galvo_cfg_pkg::*;
   import galvo_seq_pkg::*;
(
   input  logic                       s_axi_h_aclk,
   input  logic                       rst_control_n,
   input  logic                       pixel_pulse,
   input  logic                       row_wrap,
   input  logic                       manual_mode,
   input  manual_pos_t                manual,
   input  logic [`GALVO_SAMPLE_W-1:0] h_sample,
   input  logic [`GALVO_SAMPLE_W-1:0] v_sample,
   input  logic                       spi_busy,
   output logic                       spi_start,
   output dac_word_t                  spi_word,
   output logic                       galvo_spi_done
);

   localparam int GAP_W = $clog2(`GALVO_GAP_CYCLES + 1);
   localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`GALVO_GAP_CYCLES - 1);

   seq_state_e       state_q;
   seq_state_e       state_d;
   logic [GAP_W-1:0] gap_q;
   logic             gap_zero;
   logic             v_pending_q;  // row wrapped, v word owed
   logic             v_due;
   logic             send_end;
   logic             v_go;         // last gap cycle, v word next
   logic             last_gap;     // last gap cycle of the pixel

   assign gap_zero = (gap_q == '0);
   assign v_due    = v_pending_q || manual_mode;
   assign send_end = !spi_busy && !spi_start;  // frame over, csn back high
   assign v_go     = (state_q == ST_GAP_H) && gap_zero && v_due;
   assign last_gap = gap_zero && (((state_q == ST_GAP_H) && !v_due) || (state_q == ST_GAP_V));

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE:   if (pixel_pulse) state_d = ST_PREP;  // pulses elsewhere are dropped
         ST_PREP:   state_d = ST_SEND_H;                 // ram reads new position
         ST_SEND_H: if (send_end) state_d = ST_GAP_H;
         ST_GAP_H:  if (gap_zero) state_d = v_due ? ST_SEND_V : ST_IDLE;
         ST_SEND_V: if (send_end) state_d = ST_GAP_V;
         ST_GAP_V:  if (gap_zero) state_d = ST_IDLE;
         default:   state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         state_q        <= ST_IDLE;
         spi_start      <= 1'b0;
         galvo_spi_done <= 1'b0;
      end else begin
         state_q        <= state_d;
         spi_start      <= (state_q == ST_PREP) || v_go;  // high in first send cycle
         galvo_spi_done <= last_gap;
      end
   end

   // gap counter reloads for as long as a frame is on the wire
   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         gap_q <= '0;
      end else if (state_q == ST_SEND_H || state_q == ST_SEND_V) begin
         gap_q <= GAP_LAST;
      end else if (!gap_zero) begin
         gap_q <= gap_q - 1'b1;
      end
   end

   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         v_pending_q <= 1'b0;
      end else if (row_wrap) begin
         v_pending_q <= 1'b1;  // wins over clear, a new row is owed
      end else if (v_go) begin
         v_pending_q <= 1'b0;
      end
   end

   // word follows the state, memory data valid from the first send cycle
   always_comb begin
      if (state_q == ST_SEND_V) begin
         spi_word.cmd    = CMD_LOAD_B;
         spi_word.sample = manual_mode ? manual.v_pos : v_sample;
      end else begin
         spi_word.cmd    = CMD_LOAD_A;
         spi_word.sample = manual_mode ? manual.h_pos : h_sample;
      end
   end

   // a word only goes out once the previous gap has run out
   a_start_after_gap: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
      spi_start |-> gap_zero && !spi_busy);

endmodule

/* rtl/dac_spi_master.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module dac_spi_master
   import galvo_seq_pkg::*;
(
   input  logic      s_axi_h_aclk,
   input  logic      rst_control_n,
   input  logic      start,
   input  dac_word_t word,
   output logic      busy,
   output logic      sclk,
   output logic      csn,
   output logic      mosi
);

   localparam int DIV        = `GALVO_SCLK_DIV;
   localparam int DIV_W      = (DIV > 1) ? $clog2(DIV) : 1;
   localparam int BIT_W      = $clog2(`GALVO_WORD_W);
   localparam int FRAME_CLKS = `GALVO_WORD_W * 2 * DIV;

   logic [`GALVO_WORD_W-1:0] shift_q;
   logic [DIV_W-1:0]         div_q;    // clocks into the half period
   logic [BIT_W-1:0]         bit_q;
   logic                     half_end;
   logic                     last_bit;

   assign half_end = (div_q == DIV_W'(DIV - 1));
   assign last_bit = (bit_q == BIT_W'(`GALVO_WORD_W - 1));
   assign mosi     = shift_q[`GALVO_WORD_W-1];  // msb first

   always_ff @(posedge s_axi_h_aclk or negedge rst_control_n) begin
      if (!rst_control_n) begin
         shift_q <= '0;
         div_q   <= '0;
         bit_q   <= '0;
         sclk    <= 1'b0;  // mode 0 idle
         csn     <= 1'b1;
         busy    <= 1'b0;
      end else if (start) begin
         shift_q <= word;
         div_q   <= '0;
         bit_q   <= '0;
         csn     <= 1'b0;
         busy    <= 1'b1;
      end else if (!csn) begin
         if (half_end) begin
            div_q <= '0;
            sclk  <= ~sclk;
            if (sclk) begin  // falling edge, next bit while sclk low
               shift_q <= {shift_q[`GALVO_WORD_W-2:0], 1'b0};
               bit_q   <= bit_q + 1'b1;
               csn     <= last_bit;
            end
         end else begin
            div_q <= div_q + 1'b1;
         end
      end else if (busy) begin
         busy <= 1'b0;  // one cycle after csn rise
      end
   end

   a_no_start_busy: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
      start |-> !busy);

   // csn went low exactly one frame before each rise
   a_csn_frame: assert property (@(posedge s_axi_h_aclk) disable iff (!rst_control_n)
      $rose(csn) |-> ($past(csn, FRAME_CLKS + 1) && !$past(csn, FRAME_CLKS)));

endmodule

/* rtl/galvo_top.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module galvo_top
   import galvo_cfg_pkg::*;
   import galvo_seq_pkg::*;
(
   input  logic                    s_axi_h_aclk,
   input  logic                    rst_control_n,
   input  logic                    clk_adc,
   input  logic                    rst_adc_n,
   input  logic                    pixel_done,
   input  scan_cfg_t               cfg,
   input  manual_pos_t             manual,
   input  vec_wr_t                 vec_wr,      // host memory load
   output logic                    sclk,
   output logic                    csn,
   output logic                    mosi,
   output logic [`GALVO_POS_W-1:0] galvoh,      // position readback
   output logic [`GALVO_POS_W-1:0] galvov,
   output logic                    galvo_spi_done
);

   logic                       pixel_pulse;
   logic                       row_wrap;
   logic [`GALVO_SAMPLE_W-1:0] h_sample;
   logic [`GALVO_SAMPLE_W-1:0] v_sample;
   logic                       spi_start;
   logic                       spi_busy;
   dac_word_t                  spi_word;

   pulse_sync u_sync (
      .clk_adc       (clk_adc),
      .rst_adc_n     (rst_adc_n),
      .pixel_done    (pixel_done),
      .s_axi_h_aclk  (s_axi_h_aclk),
      .rst_control_n (rst_control_n),
      .pixel_pulse   (pixel_pulse)
   );

   scan_position u_pos (
      .s_axi_h_aclk  (s_axi_h_aclk),
      .rst_control_n (rst_control_n),
      .pixel_pulse   (pixel_pulse),
      .cfg           (cfg),
      .h_pos         (galvoh),
      .v_pos         (galvov),
      .row_wrap      (row_wrap)
   );

   vector_ram ram_h (
      .s_axi_h_aclk (s_axi_h_aclk),
      .wr_en        (vec_wr.en && (vec_wr.axis == AXIS_H)),  // axis decode
      .wr_addr      (vec_wr.addr),
      .wr_data      (vec_wr.data),
      .rd_addr      (galvoh),
      .rd_data      (h_sample)
   );

   vector_ram ram_v (
      .s_axi_h_aclk (s_axi_h_aclk),
      .wr_en        (vec_wr.en && (vec_wr.axis == AXIS_V)),
      .wr_addr      (vec_wr.addr),
      .wr_data      (vec_wr.data),
      .rd_addr      (galvov),
      .rd_data      (v_sample)
   );

   galvo_sequencer u_seq (
      .s_axi_h_aclk   (s_axi_h_aclk),
      .rst_control_n  (rst_control_n),
      .pixel_pulse    (pixel_pulse),
      .row_wrap       (row_wrap),
      .manual_mode    (cfg.manual_mode),
      .manual         (manual),
      .h_sample       (h_sample),
      .v_sample       (v_sample),
      .spi_busy       (spi_busy),
      .spi_start      (spi_start),
      .spi_word       (spi_word),
      .galvo_spi_done (galvo_spi_done)
   );

   dac_spi_master u_spi (
      .s_axi_h_aclk  (s_axi_h_aclk),
      .rst_control_n (rst_control_n),
      .start         (spi_start),
      .word          (spi_word),
      .busy          (spi_busy),
      .sclk          (sclk),
      .csn           (csn),
      .mosi          (mosi)
   );

endmodule

/* dv/galvo_tb.sv */
`timescale 1ns/1ps
`include "galvo_defs.svh"

module galvo_tb
   import galvo_cfg_pkg::*;
   import galvo_seq_pkg::*;
();

   localparam int LOAD_DEPTH  = 64;     // entries loaded per axis, scan uses 0..3
   localparam int PIXEL_WAIT  = 400;    // two frames plus gaps stay under 200 cycles
   // about 30 pixels at 200 cycles, memory load and idle gaps, with wide margin
   localparam int CYCLE_LIMIT = 20000;

   localparam logic [3:0] DAC_CMD_H = 4'b0001;  // dac channel a load
   localparam logic [3:0] DAC_CMD_V = 4'b0100;  // dac channel b load

   logic                    s_axi_h_aclk;
   logic                    rst_control_n;
   logic                    clk_adc;
   logic                    rst_adc_n;
   logic                    pixel_done;
   scan_cfg_t               cfg;
   manual_pos_t             manual;
   vec_wr_t                 vec_wr;
   logic                    sclk;
   logic                    csn;
   logic                    mosi;
   logic [`GALVO_POS_W-1:0] galvoh;
   logic [`GALVO_POS_W-1:0] galvov;
   logic                    galvo_spi_done;

   integer      seed        = 26;
   int          errors      = 0;
   int          mon_errors  = 0;  // raised by the bus monitor
   int          checks      = 0;
   int          cycles      = 0;
   int          done_cnt    = 0;
   int          pixels_sent = 0;
   int          done_pixel  = -1;  // pixel count seen at the last done pulse
   int          bit_cnt     = 0;
   logic        csn_prev    = 1'b1;
   logic        done_prev   = 1'b0;
   logic [15:0] shift_word  = '0;
   logic [15:0] frames[$];         // every word seen on mosi

   logic [`GALVO_SAMPLE_W-1:0] model_h [1 << `GALVO_POS_W];
   logic [`GALVO_SAMPLE_W-1:0] model_v [1 << `GALVO_POS_W];
   logic [`GALVO_POS_W-1:0]    exp_h;
   logic [`GALVO_POS_W-1:0]    exp_v;

   galvo_top dut0 (
      .s_axi_h_aclk   (s_axi_h_aclk),
      .rst_control_n  (rst_control_n),
      .clk_adc        (clk_adc),
      .rst_adc_n      (rst_adc_n),
      .pixel_done     (pixel_done),
      .cfg            (cfg),
      .manual         (manual),
      .vec_wr         (vec_wr),
      .sclk           (sclk),
      .csn            (csn),
      .mosi           (mosi),
      .galvoh         (galvoh),
      .galvov         (galvov),
      .galvo_spi_done (galvo_spi_done)
   );

   initial begin
      s_axi_h_aclk = 1'b0;
      forever #20 s_axi_h_aclk = ~s_axi_h_aclk;  // 25 MHz control
   end

   initial begin
      clk_adc = 1'b0;
      forever #15 clk_adc = ~clk_adc;  // unrelated adc clock
   end

   always @(posedge s_axi_h_aclk) begin
      cycles = cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("run did not finish within %0d control cycles", CYCLE_LIMIT);
         $display("checks %0d, errors %0d, monitor errors %0d", checks, errors, mon_errors);
         $display("TEST FAIL");
         $finish;
      end
   end

   // mode 0, mosi stable on sclk rise
   always @(posedge sclk) begin
      if (!csn) begin
         shift_word = {shift_word[14:0], mosi};
         if (bit_cnt == 15) begin
            frames.push_back(shift_word);
            bit_cnt = 0;
         end else begin
            bit_cnt = bit_cnt + 1;
         end
      end
   end

   always @(negedge s_axi_h_aclk) begin
      if (csn_prev && !csn) begin  // frame start
         assert (done_pixel != pixels_sent) else begin
            mon_errors++;
            $display("a frame started after the done pulse and before the next pixel_done");
         end
      end
      if (!csn_prev && csn) begin
         assert (bit_cnt == 0) else begin
            mon_errors++;
            $display("a frame ended after %0d of 16 bits", bit_cnt);
         end
      end
      if (galvo_spi_done) begin
         done_cnt++;
         done_pixel = pixels_sent;
         assert (!done_prev) else begin
            mon_errors++;
            $display("galvo_spi_done stayed high for more than one cycle");
         end
         assert (csn) else begin
            mon_errors++;
            $display("galvo_spi_done came while a frame was still on the wire");
         end
      end
      csn_prev  = csn;
      done_prev = galvo_spi_done;
   end

   task automatic check_value(input string test, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("[ERROR] %s: %s expected %h, actual %h", test, what, exp, act);
      end
   endtask

   // one clk_adc cycle wide
   task automatic send_pixel();
      @(posedge clk_adc);
      #2 pixel_done = 1'b1;
      pixels_sent++;
      @(posedge clk_adc);
      #2 pixel_done = 1'b0;
   endtask

   // step the reference counters, report a row wrap
   task automatic advance_model(output bit wrap);
      wrap = (exp_h == cfg.h_max);
      if (wrap) begin
         exp_h = '0;
         exp_v = (exp_v == cfg.v_max) ? '0 : exp_v + 1'b1;
      end else begin
         exp_h = exp_h + 1'b1;
      end
   endtask

   task automatic wait_done(input string test, input int start_cnt);
      int waited;
      waited = 0;
      while (done_cnt == start_cnt && waited < PIXEL_WAIT) begin
         @(negedge s_axi_h_aclk);
         waited++;
      end
      checks++;
      assert (done_cnt != start_cnt) else begin
         errors++;
         $display("%s: no done pulse within %0d cycles of pixel_done", test, PIXEL_WAIT);
      end
   endtask

   // one pixel, expected words built from the model memories
   task automatic run_pixel(input string test);
      bit          wrap;
      int          start_cnt;
      int          base;
      logic [15:0] exp_words[$];
      logic [15:0] got;
      start_cnt = done_cnt;
      base      = frames.size();
      send_pixel();
      advance_model(wrap);
      if (cfg.manual_mode) begin
         exp_words.push_back({DAC_CMD_H, manual.h_pos});
         exp_words.push_back({DAC_CMD_V, manual.v_pos});  // every pixel
      end else begin
         exp_words.push_back({DAC_CMD_H, model_h[exp_h]});
         if (wrap) begin
            exp_words.push_back({DAC_CMD_V, model_v[exp_v]});
         end
      end
      wait_done(test, start_cnt);
      repeat (4) @(negedge s_axi_h_aclk);
      check_value(test, "done pulses", start_cnt + 1, done_cnt);
      check_value(test, "galvoh", 32'(exp_h), 32'(galvoh));
      check_value(test, "galvov", 32'(exp_v), 32'(galvov));
      check_value(test, "frame count", exp_words.size(), frames.size() - base);
      foreach (exp_words[i]) begin
         got = (base + i < frames.size()) ? frames[base + i] : 'x;
         check_value(test, "spi word", 32'(exp_words[i]), 32'(got));
      end
   endtask

   task automatic load_memories();
      logic [`GALVO_POS_W-1:0] addr;
      addr = '0;
      repeat (LOAD_DEPTH) begin
         model_h[addr] = 12'($random(seed));
         model_v[addr] = 12'($random(seed));
         @(posedge s_axi_h_aclk);
         #2 vec_wr.en = 1'b1;
         vec_wr.axis = AXIS_H;
         vec_wr.addr = addr;
         vec_wr.data = model_h[addr];
         @(posedge s_axi_h_aclk);
         #2 vec_wr.axis = AXIS_V;
         vec_wr.data = model_v[addr];
         addr = addr + 1'b1;
      end
      @(posedge s_axi_h_aclk);
      #2 vec_wr.en = 1'b0;
   endtask

   task automatic test_reset();
      @(negedge s_axi_h_aclk);
      check_value("reset", "csn", 32'(1), 32'(csn));
      check_value("reset", "sclk", 32'(0), 32'(sclk));
      check_value("reset", "galvo_spi_done", 32'(0), 32'(galvo_spi_done));
      check_value("reset", "galvoh", 32'(0), 32'(galvoh));
      check_value("reset", "galvov", 32'(0), 32'(galvov));
   endtask

   task automatic test_manual();
      @(posedge s_axi_h_aclk);
      #2 cfg.manual_mode = 1'b1;
      manual.h_pos = 12'h5a3;
      manual.v_pos = 12'hc3e;
      repeat (6) run_pixel("manual");
      @(posedge s_axi_h_aclk);
      #2 cfg.manual_mode = 1'b0;
   endtask

   // nothing may move on the bus once the pixel is done
   task automatic test_done_gap();
      int start_cnt;
      int base;
      run_pixel("done_gap");
      start_cnt = done_cnt;
      base      = frames.size();
      repeat (120) @(negedge s_axi_h_aclk);
      check_value("done_gap", "done pulses", start_cnt, done_cnt);
      check_value("done_gap", "frame count", base, frames.size());
   endtask

   task automatic test_busy();
      bit          wrap;
      int          start_cnt;
      int          base;
      logic [15:0] exp_word;
      while (exp_h != '0) run_pixel("busy_align");  // neither pulse may wrap
      start_cnt = done_cnt;
      base      = frames.size();
      send_pixel();
      advance_model(wrap);
      exp_word = {DAC_CMD_H, model_h[exp_h]};
      repeat (8) @(posedge clk_adc);  // lands inside the first frame
      send_pixel();
      advance_model(wrap);
      wait_done("busy", start_cnt);
      repeat (150) @(negedge s_axi_h_aclk);
      check_value("busy", "done pulses", start_cnt + 1, done_cnt);
      check_value("busy", "frame count", 1, frames.size() - base);
      if (frames.size() > base) begin
         check_value("busy", "spi word", 32'(exp_word), 32'(frames[base]));
      end
      check_value("busy", "galvoh", 32'(2), 32'(galvoh));
   endtask

   initial begin
      rst_control_n = 1'b0;
      rst_adc_n     = 1'b0;
      pixel_done    = 1'b0;
      cfg           = '0;
      cfg.h_max     = 11'd3;
      cfg.v_max     = 11'd2;
      manual        = '0;
      vec_wr        = '0;
      exp_h         = '0;
      exp_v         = '0;
      repeat (5) @(posedge s_axi_h_aclk);
      #2 rst_control_n = 1'b1;
      rst_adc_n = 1'b1;
      test_reset();
      load_memories();
      repeat (4) run_pixel("row_scan");     // first row, one wrap
      repeat (13) run_pixel("frame_wrap");  // full frame wrap of galvov
      test_manual();
      test_done_gap();
      test_busy();
      repeat (10) @(negedge s_axi_h_aclk);
      $display("checks %0d, errors %0d, monitor errors %0d", checks, errors, mon_errors);
      if (errors == 0 && mon_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+rtl
rtl/galvo_seq_pkg.sv
rtl/galvo_cfg_pkg.sv
rtl/pulse_sync.sv
rtl/scan_position.sv
rtl/vector_ram.sv
rtl/galvo_sequencer.sv
rtl/dac_spi_master.sv
rtl/galvo_top.sv
dv/galvo_tb.sv

/* run.sh */
#!/bin/sh
# build and run the galvo scan controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module galvo_tb -o sim_galvo

./obj_dir/sim_galvo | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
   exit 0
else
   echo "simulation did not pass, see sim.log"
   exit 1
fi
